/* Makefile */
# Verilator lint, build and run of the binary32 square root testbench
# any variable can be set on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP ?= fpSqrt32nr_tb
FILELIST ?= fpSqrt32nr.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
# keep running after an assertion error so the testbench prints its verdict
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the run printed the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* fpSqrt32nr.f */
+incdir+source
source/fpSqrtPkg.sv
source/fpDecomp32.sv
source/isqrt.sv
source/fpSqrt32.sv
source/fpNormRound32.sv
source/fpSqrt32nr.sv
sim/clockGen.sv
sim/fpSqrt32nr_checker.sv
sim/fpSqrt32nr_tb.sv

/* sim/clockGen.sv */
// free-running clock from time zero; rstN is released on a rising edge after RESET_CYCLES edges
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter real PERIOD = 4.0,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rstN
);

	// 50 percent duty cycle, first rising edge at half a period
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// release lands after the flops have sampled the edge
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/fpSqrt32nr_checker.sv */
// models the top's busy window from ld alone; assumes the fixed 29-cycle latency of the top
`timescale 1ns/100ps
`default_nettype none

module fpSqrt32nr_checker (
	input  logic clk,
	input  logic rstN,
	input  logic ld,
	input  logic done,
	input  logic sqrInf,
	input  logic sqrNeg
);

	localparam int LATENCY = 29;

	logic [5:0] left;
	logic ldTaken;
	logic accept;
	int doneErrs = 0;
	int latErrs = 0;
	int flagErrs = 0;
	int failCount;

	// ------------------------------------------------------------------
	// busy model
	// ------------------------------------------------------------------

	// a new ld is taken on the edge that raises done, not before
	assign accept = ld && (left <= 6'd1);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			left <= '0;
			ldTaken <= 1'b0;
		end else begin
			// registered accept, done trails it by LATENCY samples
			ldTaken <= accept;
			if (accept)
				left <= 6'(LATENCY);
			else if (left != '0)
				left <= left - 1'b1;
		end
	end

	assign failCount = doneErrs + latErrs + flagErrs;

	// ------------------------------------------------------------------
	// properties
	// ------------------------------------------------------------------

	// done is a single-cycle pulse
	donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
		else begin
			doneErrs++;
			$error("done stayed high for two cycles");
		end

	doneLatency: assert property (@(posedge clk) disable iff (!rstN)
		ldTaken |-> ##(LATENCY) done)
		else begin
			latErrs++;
			$error("done missing %0d cycles after an accepted ld", LATENCY);
		end

	// the two exception flags exclude each other
	flagsExclusive: assert property (@(posedge clk) disable iff (!rstN) !(sqrInf && sqrNeg))
		else begin
			flagErrs++;
			$error("sqrInf and sqrNeg high together");
		end

endmodule

bind fpSqrt32nr fpSqrt32nr_checker protoCheck (
	.clk(clk),
	.rstN(rstN),
	.ld(ld),
	.done(done),
	.sqrInf(sqrInf),
	.sqrNeg(sqrNeg)
);

`default_nettype wire

/* sim/fpSqrt32nr_tb.sv */
// directed tests; the reference root covers positive normals only, specials use fixed words
`timescale 1ns/100ps
`default_nettype none

`include "fpSqrt_cfg.svh"

module fpSqrt32nr_tb import fpSqrtPkg::*; ();

	localparam int LATENCY = 29;
	localparam int WAIT_LIMIT = 40;
	// exact 20, normals 110, specials 7, subnormals 2, handshake about 2
	localparam int N_OPS = 141;
	localparam int TIMEOUT_CYCLES = N_OPS * 35 + 100;
	localparam logic [`FP_FRAC_W-1:0] QUIET = 23'h400000;

	logic clk;
	logic rstN;
	logic ld;
	fpWord a;
	roundMode rm;
	fpWord o;
	logic done;
	logic inf;
	logic sqrInf;
	logic sqrNeg;

	integer seed;
	int cycleCount = 0;
	int wordErrs = 0;
	int flagErrs = 0;
	int cycleErrs = 0;
	int otherErrs = 0;
	int total;

	clockGen #(.PERIOD(4.0), .RESET_CYCLES(3)) u0 (.clk(clk), .rstN(rstN));

	fpSqrt32nr i_dut (
		.clk(clk),
		.rstN(rstN),
		.ld(ld),
		.a(a),
		.rm(rm),
		.o(o),
		.done(done),
		.inf(inf),
		.sqrInf(sqrInf),
		.sqrNeg(sqrNeg)
	);

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------

	task automatic checkWord(input string name, input fpWord got, input fpWord want);
		if (got !== want) begin
			wordErrs++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got.raw, want.raw);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic want);
		if (got !== want) begin
			flagErrs++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic checkCycles(input string name, input int got, input int want);
		if (got != want) begin
			cycleErrs++;
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	// ------------------------------------------------------------------
	// reference root for positive normals
	// ------------------------------------------------------------------

	// 1.f scaled by 2^50 (2^51 for odd exponents) so the root has 24 bits plus guard and round
	function automatic fpWord refSqrt(input fpWord x, input roundMode m);
		logic [63:0] scaled;
		logic [63:0] root;
		logic [63:0] cand;
		logic [24:0] mant;
		logic [`FP_FRAC_W-1:0] frac;
		logic guardBit;
		logic stickyBit;
		logic above;
		logic tie;
		logic bump;
		int unbiased;
		int halfExp;
		int b;
		fpWord res;
		unbiased = int'(x.f.exp) - `FP_BIAS;
		scaled = {40'd0, 1'b1, x.f.frac} << 27;
		if (unbiased % 2 != 0) begin
			scaled = scaled << 1;
			unbiased = unbiased - 1;
		end
		halfExp = unbiased / 2;
		// bitwise floor root of a value below 2^53
		root = '0;
		for (b = 26; b >= 0; b--) begin
			cand = root | (64'd1 << b);
			if (cand * cand <= scaled)
				root = cand;
		end
		guardBit = root[1];
		stickyBit = (root * root != scaled);
		above = guardBit & (root[0] | stickyBit);
		tie = guardBit & ~root[0] & ~stickyBit;
		// down truncates and up bumps on any loss since the result is positive
		case (m)
			RNE: bump = above | (tie & root[2]);
			RUP: bump = root[1] | root[0] | stickyBit;
			RMM: bump = guardBit;
			default: bump = 1'b0;
		endcase
		mant = {1'b0, root[25:2]} + 25'(bump);
		if (mant[24]) begin
			halfExp = halfExp + 1;
			frac = mant[23:1];
		end else begin
			frac = mant[22:0];
		end
		res.raw = {1'b0, 8'(halfExp + `FP_BIAS), frac};
		return res;
	endfunction

	// ------------------------------------------------------------------
	// one operation driven, awaited and checked
	// ------------------------------------------------------------------

	task automatic runOp(input fpWord x, input roundMode m, input fpWord want,
		input logic wantInf, input logic wantSqrInf, input logic wantSqrNeg);
		int lat;
		lat = 0;
		@(posedge clk);
		ld <= 1'b1;
		a <= x;
		rm <= m;
		@(posedge clk);
		ld <= 1'b0;
		// lat is the index of the last rising edge since ld was sampled
		@(negedge clk);
		while (!done && lat < WAIT_LIMIT) begin
			lat++;
			@(negedge clk);
		end
		if (!done) begin
			otherErrs++;
			$display("ERROR: no done within %0d cycles for operand %h", WAIT_LIMIT, x.raw);
		end else begin
			checkCycles("ld to done", lat, LATENCY);
			checkWord("o", o, want);
			checkFlag("inf", inf, wantInf);
			checkFlag("sqrInf", sqrInf, wantSqrInf);
			checkFlag("sqrNeg", sqrNeg, wantSqrNeg);
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------

	task automatic checkReset();
		checkFlag("done", done, 1'b0);
		checkFlag("inf", inf, 1'b0);
		checkFlag("sqrInf", sqrInf, 1'b0);
		checkFlag("sqrNeg", sqrNeg, 1'b0);
		checkWord("o", o, 32'h0);
	endtask

	// 1.0, 4.0, 2.25 and 0.25 root exactly in every mode
	task automatic testExactSquares();
		logic [31:0] ops [4];
		logic [31:0] roots [4];
		int k;
		int j;
		ops = '{32'h3F800000, 32'h40800000, 32'h40100000, 32'h3E800000};
		roots = '{32'h3F800000, 32'h40000000, 32'h3FC00000, 32'h3F000000};
		for (k = 0; k < 5; k++)
			for (j = 0; j < 4; j++)
				runOp(ops[j], roundMode'(k), roots[j], 1'b0, 1'b0, 1'b0);
	endtask

	task automatic testRandomNormals();
		fpWord x;
		int e;
		int n;
		int k;
		for (n = 0; n < 22; n++) begin
			// smallest and largest normal come first
			if (n == 0) begin
				x = 32'h00800000;
			end else if (n == 1) begin
				x = 32'h7F7FFFFF;
			end else begin
				e = 1 + ($unsigned($random(seed)) % 254);
				x.raw = {1'b0, 8'(e), 23'($random(seed))};
			end
			for (k = 0; k < 5; k++)
				runOp(x, roundMode'(k), refSqrt(x, roundMode'(k)), 1'b0, 1'b0, 1'b0);
		end
	endtask

	task automatic testSpecials();
		fpWord negNan;
		negNan.raw = {1'b0, 8'hFF, QUIET | `QNAN_SQRTNEG};
		runOp(32'h00000000, RNE, 32'h00000000, 1'b0, 1'b0, 1'b0);
		runOp(32'h80000000, RTZ, 32'h80000000, 1'b0, 1'b0, 1'b0);
		runOp(32'h7F800000, RNE, 32'h7F800000, 1'b1, 1'b1, 1'b0);
		// quiet NaN passes as is
		runOp(32'h7FC12345, RUP, 32'h7FC12345, 1'b0, 1'b0, 1'b0);
		// signalling NaN comes back quiet with sign and payload kept
		runOp(32'hFF812345, RDN, 32'hFFC12345, 1'b0, 1'b0, 1'b0);
		runOp(32'hC0800000, RNE, negNan, 1'b0, 1'b0, 1'b1);
		runOp(32'hFF800000, RMM, negNan, 1'b0, 1'b0, 1'b1);
	endtask

	// subnormals flush to a zero of the same sign
	task automatic testSubnormals();
		runOp(32'h00000001, RUP, 32'h00000000, 1'b0, 1'b0, 1'b0);
		runOp(32'h807FFFFF, RDN, 32'h80000000, 1'b0, 1'b0, 1'b0);
	endtask

	// second ld mid-operation is dropped and the result holds with no extra done
	task automatic testHandshake();
		fpWord x;
		fpWord want;
		int lat;
		int n;
		x = 32'h40000000;
		want = refSqrt(x, RNE);
		@(posedge clk);
		ld <= 1'b1;
		a <= x;
		rm <= RNE;
		@(posedge clk);
		ld <= 1'b0;
		repeat (4) @(posedge clk);
		ld <= 1'b1;
		a <= 32'h41100000;
		@(posedge clk);
		ld <= 1'b0;
		a <= '0;
		lat = 5;
		@(negedge clk);
		while (!done && lat < WAIT_LIMIT) begin
			lat++;
			@(negedge clk);
		end
		if (!done) begin
			otherErrs++;
			$display("ERROR: no done within %0d cycles in the busy-ld test", WAIT_LIMIT);
		end else begin
			checkCycles("ld to done", lat, LATENCY);
			checkWord("o", o, want);
		end
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge clk);
			if (done) begin
				otherErrs++;
				$display("ERROR: extra done at t=%0t after an ld issued while busy", $time);
			end
			checkWord("o held", o, want);
		end
	endtask

	// ------------------------------------------------------------------
	// run control
	// ------------------------------------------------------------------

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("ERROR: run stopped at the limit of %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		ld <= 1'b0;
		a <= '0;
		rm <= RNE;
		seed = 73645;
		@(posedge rstN);
		@(negedge clk);
		checkReset();
		testExactSquares();
		testRandomNormals();
		testSpecials();
		testSubnormals();
		testHandshake();
		total = wordErrs + flagErrs + cycleErrs + otherErrs + i_dut.protoCheck.failCount;
		$display("errors: %0d (word %0d, flag %0d, latency %0d, other %0d, assertion %0d)",
			total, wordErrs, flagErrs, cycleErrs, otherErrs, i_dut.protoCheck.failCount);
		if (total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* source/fpDecomp32.sv */
// one cycle latency; any zero exponent reads as zero, so subnormals are flushed
`timescale 1ns/100ps
`default_nettype none

module fpDecomp32 import fpSqrtPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  fpWord i,
	output fpDecoded o
);

	logic expZero;
	logic expMax;
	logic fracZero;
	logic nan;

	// ------------------------------------------------------------------
	// field classification
	// ------------------------------------------------------------------

	always_comb begin
		expZero = (i.f.exp == '0);
		expMax = (i.f.exp == '1);
		fracZero = (i.f.frac == '0);
		// all-ones exponent with any fraction bit set
		nan = expMax & ~fracZero;
	end

	// ------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			o <= '0;
		end else begin
			o.sign <= i.f.sign;
			o.exp <= i.f.exp;
			// hidden bit is set for every normal
			o.frac <= {~expZero, i.f.frac};
			// fraction is ignored when the exponent is zero
			o.isZero <= expZero;
			o.isInf <= expMax & fracZero;
			o.isNan <= nan;
			// negative zero and negative NaN are not a negative operand
			o.isNeg <= i.f.sign & ~expZero & ~nan;
		end
	end

endmodule

`default_nettype wire

/* source/fpNormRound32.sv */
// no overflow or underflow handling, the root of a normal cannot leave the normal range
`timescale 1ns/100ps
`default_nettype none

`include "fpSqrt_cfg.svh"

module fpNormRound32 import fpSqrtPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  fpRaw i,
	input  logic iValid,
	input  roundMode rm,
	output fpWord o,
	output logic oValid
);

	localparam int SW = `ISQRT_ITER;

	logic [SW-1:0] sig;
	logic [`FP_EXP_W:0] exp;
	logic lsb;
	logic guard;
	logic rnd;
	logic inexact;
	logic up;
	logic carry;
	logic [`FP_FRAC_W+1:0] mant;
	logic [`FP_EXP_W:0] expR;
	logic [`FP_FRAC_W-1:0] fracR;
	fpWord res;

	// ------------------------------------------------------------------
	// normalize
	// ------------------------------------------------------------------

	// root lies in [1,2), so one left shift at most
	always_comb begin
		if (i.sig[SW-1]) begin
			sig = i.sig;
			exp = i.exp;
		end else begin
			sig = i.sig << 1;
			exp = i.exp - 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// round
	// ------------------------------------------------------------------

	always_comb begin
		lsb = sig[2];
		guard = sig[1];
		rnd = sig[0];
		inexact = guard | rnd | i.sticky;
		case (rm)
			RNE: up = guard & (rnd | i.sticky | lsb);
			RTZ: up = 1'b0;
			RDN: up = i.sign & inexact;
			RUP: up = ~i.sign & inexact;
			RMM: up = guard;
			default: up = 1'b0;
		endcase

		// hidden bit plus fraction, one spare bit for the carry
		mant = {1'b0, sig[SW-1:2]} + (`FP_FRAC_W+2)'(up);
		carry = mant[`FP_FRAC_W+1];
		fracR = carry ? mant[`FP_FRAC_W:1] : mant[`FP_FRAC_W-1:0];
		expR = exp + (`FP_EXP_W+1)'(carry);

		// specials go through untouched
		if (i.isSpecial) begin
			res.f.sign = i.sign;
			res.f.exp = i.exp[`FP_EXP_W-1:0];
			res.f.frac = i.sig[SW-2:2];
		end else begin
			res.f.sign = i.sign;
			res.f.exp = expR[`FP_EXP_W-1:0];
			res.f.frac = fracR;
		end
	end

	// ------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------

	// o holds between results
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			o <= '0;
			oValid <= 1'b0;
		end else begin
			oValid <= iValid;
			if (iValid)
				o <= res;
		end
	end

endmodule

`default_nettype wire

/* source/fpSqrt32.sv */
// ld while busy is dropped; raw and the flags hold from rawValid until the next result
`timescale 1ns/100ps
`default_nettype none

`include "fpSqrt_cfg.svh"

module fpSqrt32 import fpSqrtPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic ld,
	input  fpWord a,
	output fpRaw raw,
	output logic rawValid,
	output logic sqrInf,
	output logic sqrNeg
);

	localparam int RAD_W = 2*`ISQRT_ITER;
	localparam int SIG_W = `FP_FRAC_W + 1;
	localparam logic [`FP_FRAC_W-1:0] QNAN_BIT = {1'b1, {(`FP_FRAC_W-1){1'b0}}};
	localparam logic [`FP_EXP_W:0] HALF_BIAS = (`FP_EXP_W+1)'(`FP_BIAS >> 1);
	localparam logic [`FP_EXP_W:0] EXP_MAX = {1'b0, {`FP_EXP_W{1'b1}}};

	logic busy;
	logic accept;
	logic rootStart;
	logic rootDone;
	logic rootSticky;
	logic special;
	fpWord aHold;
	fpWord decIn;
	fpDecoded dec;
	logic [`FP_EXP_W:0] ex1;
	logic [`FP_EXP_W:0] xo;
	logic [RAD_W-1:0] radicand;
	logic [`ISQRT_ITER-1:0] root;
	logic [`FP_FRAC_W-1:0] excCode;

	// ------------------------------------------------------------------
	// operand capture and decode
	// ------------------------------------------------------------------

	assign accept = ld & ~busy;

	// decoder sees the new operand on accept, then the held copy,
	// so dec stays put for the whole operation
	assign decIn = accept ? a : aHold;

	always_ff @(posedge clk) begin
		if (accept)
			aHold <= a;
	end

	fpDecomp32 u1 (
		.clk(clk),
		.rstN(rstN),
		.i(decIn),
		.o(dec)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			rootStart <= 1'b0;
		end else begin
			// root starts once the decoded operand is registered
			rootStart <= accept;
			if (accept)
				busy <= 1'b1;
			else if (rootDone)
				busy <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// exponent and radicand
	// ------------------------------------------------------------------

	// biased exponent + 1, halved, plus half the bias
	// an even biased exponent is an odd unbiased one
	assign ex1 = {1'b0, dec.exp} + (`FP_EXP_W+1)'(1);
	assign xo = {1'b0, ex1[`FP_EXP_W:1]} + HALF_BIAS;

	// significand scaled to 2^50, doubled for an odd exponent
	assign radicand = ex1[0] ? {dec.frac, {(RAD_W-SIG_W){1'b0}}}
		: {1'b0, dec.frac, {(RAD_W-SIG_W-1){1'b0}}};

	isqrt u2 (
		.clk(clk),
		.rstN(rstN),
		.start(rootStart),
		.radicand(radicand),
		.root(root),
		.sticky(rootSticky),
		.rootDone(rootDone)
	);

	// ------------------------------------------------------------------
	// result select
	// ------------------------------------------------------------------

	assign special = dec.isNan | dec.isNeg | dec.isInf | dec.isZero;

	always_ff @(posedge clk) begin
		if (rootDone) begin
			raw.sticky <= rootSticky;
			raw.isSpecial <= special;
			if (dec.isNan) begin
				// quieten, payload kept
				raw.sign <= dec.sign;
				raw.exp <= EXP_MAX;
				raw.sig <= {1'b0, QNAN_BIT | dec.frac[`FP_FRAC_W-1:0], 2'b00};
			end else if (dec.isNeg) begin
				raw.sign <= 1'b0;
				raw.exp <= EXP_MAX;
				raw.sig <= {1'b0, QNAN_BIT | `QNAN_SQRTNEG, 2'b00};
			end else if (dec.isInf) begin
				raw.sign <= 1'b0;
				raw.exp <= EXP_MAX;
				raw.sig <= '0;
			end else if (dec.isZero) begin
				// signed zero
				raw.sign <= dec.sign;
				raw.exp <= '0;
				raw.sig <= '0;
			end else begin
				raw.sign <= 1'b0;
				raw.exp <= xo;
				raw.sig <= root;
			end
		end
	end

	// exception code of the last result, also the flag source
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			excCode <= '0;
			rawValid <= 1'b0;
		end else begin
			rawValid <= rootDone;
			if (rootDone) begin
				if (dec.isNeg)
					excCode <= `QNAN_SQRTNEG;
				else if (dec.isInf)
					excCode <= `QNAN_SQRTINF;
				else
					excCode <= '0;
			end
		end
	end

	assign sqrInf = (excCode == `QNAN_SQRTINF);
	assign sqrNeg = (excCode == `QNAN_SQRTNEG);

endmodule

`default_nettype wire

/* source/fpSqrt32nr.sv */
// ld to done is 29 cycles; rm must stay stable until done, no back-pressure on results
`timescale 1ns/100ps
`default_nettype none

`include "fpSqrt_cfg.svh"

module fpSqrt32nr import fpSqrtPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic ld,
	input  fpWord a,
	input  roundMode rm,
	output fpWord o,
	output logic done,
	output logic inf,
	output logic sqrInf,
	output logic sqrNeg
);

	fpRaw raw;
	logic rawValid;
	logic coreInf;
	logic coreNeg;
	logic rawIsInf;

	// ------------------------------------------------------------------
	// core and rounding stage
	// ------------------------------------------------------------------

	fpSqrt32 u1 (
		.clk(clk),
		.rstN(rstN),
		.ld(ld),
		.a(a),
		.raw(raw),
		.rawValid(rawValid),
		.sqrInf(coreInf),
		.sqrNeg(coreNeg)
	);

	fpNormRound32 u2 (
		.clk(clk),
		.rstN(rstN),
		.i(raw),
		.iValid(rawValid),
		.rm(rm),
		.o(o),
		.oValid(done)
	);

	// ------------------------------------------------------------------
	// flags, aligned with done
	// ------------------------------------------------------------------

	// special raw words pass the rounder unchanged, so this is the final value
	assign rawIsInf = raw.isSpecial && (raw.exp[`FP_EXP_W-1:0] == '1)
		&& (raw.sig[`ISQRT_ITER-2:2] == '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inf <= 1'b0;
			sqrInf <= 1'b0;
			sqrNeg <= 1'b0;
		end else if (rawValid) begin
			// the core tags the root of +inf, any other infinite word counts as well
			inf <= coreInf | rawIsInf;
			sqrInf <= coreInf;
			sqrNeg <= coreNeg;
		end
	end

endmodule

`default_nettype wire

/* source/fpSqrtPkg.sv */
// types for the binary32 root; fpRaw sig layout is hidden bit, 23 fraction bits, guard, round
`default_nettype none

`include "fpSqrt_cfg.svh"

package fpSqrtPkg;

	// ------------------------------------------------------------------
	// operand word
	// ------------------------------------------------------------------

	// field view of a binary32 word
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_FRAC_W-1:0] frac;
	} fpFields;

	// same 32 bits read raw or by field
	typedef union packed {
		logic [`FP_EXP_W+`FP_FRAC_W:0] raw;
		fpFields f;
	} fpWord;

	// ------------------------------------------------------------------
	// internal records
	// ------------------------------------------------------------------

	// decoded operand with the hidden bit in the msb of frac
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_FRAC_W:0] frac;
		logic isZero;
		logic isInf;
		logic isNan;
		logic isNeg;
	} fpDecoded;

	// unrounded root handed to the rounding stage
	// exp has one spare bit for underflow
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W:0] exp;
		logic [`ISQRT_ITER-1:0] sig;
		logic sticky;
		logic isSpecial;
	} fpRaw;

	// rounding modes encoded as on the rm pins
	typedef enum logic [2:0] {
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3,
		RMM = 3'd4
	} roundMode;

endpackage

`default_nettype wire

/* source/fpSqrt_cfg.svh */
// binary32 only; the payload codes must stay clear of the quiet bit (fraction bit 22)
`ifndef FPSQRT_CFG_SVH
`define FPSQRT_CFG_SVH

// ----------------------------------------------------------------------
// binary32 field widths
// ----------------------------------------------------------------------

// exponent and stored fraction widths
`define FP_EXP_W 8
`define FP_FRAC_W 23

// exponent of 2^0
`define FP_BIAS 127

// ----------------------------------------------------------------------
// root datapath
// ----------------------------------------------------------------------

// 24 significand bits plus guard and round
`define ISQRT_ITER 26

// payload codes or-ed into the quiet NaN
`define QNAN_SQRTINF 23'h000001
`define QNAN_SQRTNEG 23'h000002

`endif

/* source/isqrt.sv */
// start is taken only while idle; root is valid from the rootDone pulse until the next start
`timescale 1ns/100ps
`default_nettype none

`include "fpSqrt_cfg.svh"

module isqrt (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic [2*`ISQRT_ITER-1:0] radicand,
	output logic [`ISQRT_ITER-1:0] root,
	output logic sticky,
	output logic rootDone
);

	localparam int N = `ISQRT_ITER;
	localparam int CW = $clog2(N);

	logic busy;
	logic [CW-1:0] cnt;
	logic rootDoneR;

	// radicand pairs shift out of the top of radR
	logic [2*N-1:0] radR;
	logic [N+1:0] remR;
	logic [N-1:0] rootR;

	logic [N+3:0] remSh;
	logic [N+3:0] trial;
	logic [N+3:0] diff;
	logic fits;

	// ------------------------------------------------------------------
	// one restoring step
	// ------------------------------------------------------------------

	always_comb begin
		// bring down the next two radicand bits
		remSh = {remR, radR[2*N-1 -: 2]};
		// trial subtrahend is 4*root + 1
		trial = {2'b00, rootR, 2'b01};
		diff = remSh - trial;
		fits = (remSh >= trial);
	end

	// ------------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------------

	// load on start, then N steps; rootDone comes with the last step
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			cnt <= '0;
			rootDoneR <= 1'b0;
		end else begin
			rootDoneR <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				cnt <= CW'(N - 1);
			end else if (busy) begin
				if (cnt == '0) begin
					busy <= 1'b0;
					rootDoneR <= 1'b1;
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			radR <= radicand;
			remR <= '0;
			rootR <= '0;
		end else if (busy) begin
			radR <= radR << 2;
			if (fits) begin
				// remainder never exceeds 2*root, so the top bits of diff are zero
				remR <= diff[N+1:0];
				rootR <= {rootR[N-2:0], 1'b1};
			end else begin
				remR <= remSh[N+1:0];
				rootR <= {rootR[N-2:0], 1'b0};
			end
		end
	end

	assign root = rootR;
	// anything left over means the root is inexact
	assign sticky = |remR;
	assign rootDone = rootDoneR;

endmodule

`default_nettype wire
